//--- source/app_pkg.sv
/*
 * Shared bus types, address layout and build constants for the register core.
 * Imported by every RTL module through a wildcard import in the module header.
 */
`default_nettype none

package app_pkg;

    // ======================================================================
    // Bus word and address layout
    // ======================================================================

    typedef logic [31:0] opb_word_t;                // One bus data word

    typedef union packed {
        opb_word_t raw;                             // Whole address word
        struct packed {
            logic [15:0] unused;                    // Upper half not decoded
            logic [7:0]  blk;                       // Block select field
            logic [7:0]  offset;                    // Register inside block
        } fields;
    } opb_addr_u;

    typedef struct packed {
        opb_addr_u addr;                            // Access address
        opb_word_t wdata;                           // Write data
        logic      re;                              // Single cycle read strobe
        logic      we;                              // Single cycle write strobe
    } opb_req_t;                                    // 66 bits from the master

    typedef struct packed {
        logic idreg;                                // Identity and scratch
        logic tick;                                 // Tick generator
        logic gpio;                                 // GPIO and LEDs
    } blk_sel_t;

    // ======================================================================
    // Block codes and constants
    // ======================================================================

    localparam logic [7:0] BLK_IDREG = 8'h00;
    localparam logic [7:0] BLK_TICK  = 8'h01;
    localparam logic [7:0] BLK_GPIO  = 8'h02;

    // Build words used as top level defaults
    localparam opb_word_t DEF_FW_VERSION = 32'h0000_0001;
    localparam opb_word_t DEF_FPGA_ID    = 32'h0000_0100;
    localparam opb_word_t DEF_BUILD_DATE = 32'h2025_0809;  // YYYY_MMDD

    localparam int GPIO_IN_W  = 16;                 // Input bank width
    localparam int GPIO_OUT_W = 16;                 // Output bank width
    localparam int LED_W      = 3;                  // Status LED count

    localparam opb_word_t UNMAPPED_READ = 32'h0000_0000;   // Unknown block or offset

endpackage

`default_nettype wire

//--- source/opb_addr_decode.sv
/*
 * Block decoder for the register bus. Selects follow the block field at once
 * and the chosen peripheral word is captured into opb_rdata on a read strobe.
 */
`timescale 1ns/10ps
`default_nettype none

module opb_addr_decode import app_pkg::*; (
    input  logic      opb_clk,
    input  logic      rst_n,
    input  opb_req_t  opb_req,
    input  opb_word_t idreg_rdata,
    input  opb_word_t tick_rdata,
    input  opb_word_t gpio_rdata,
    output blk_sel_t  sel,
    output opb_word_t opb_rdata
);

    logic [7:0] blk;                                // Block field of this access
    opb_word_t  rd_mux;                             // Word of the addressed block

    assign blk = opb_req.addr.fields.blk;

    // One-hot selects, all low for unknown blocks
    always_comb begin
        sel = '0;
        case (blk)
            BLK_IDREG: sel.idreg = 1'b1;
            BLK_TICK:  sel.tick  = 1'b1;
            BLK_GPIO:  sel.gpio  = 1'b1;
            default:   sel       = '0;
        endcase
    end

    always_comb begin
        case (blk)
            BLK_IDREG: rd_mux = idreg_rdata;
            BLK_TICK:  rd_mux = tick_rdata;
            BLK_GPIO:  rd_mux = gpio_rdata;
            default:   rd_mux = UNMAPPED_READ;
        endcase
    end

    // Read data holds until the next read
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            opb_rdata <= '0;
        end else if (opb_req.re) begin
            opb_rdata <= rd_mux;                    // Valid from the next cycle
        end
    end

endmodule

`default_nettype wire

//--- source/id_scratch_regs.sv
/*
 * Identity block with read-only version, FPGA ID and build date words and one
 * read/write scratch word used by software to check bus access.
 */
`timescale 1ns/10ps
`default_nettype none

module id_scratch_regs import app_pkg::*; #(
    parameter opb_word_t fw_version = DEF_FW_VERSION,
    parameter opb_word_t fpga_id    = DEF_FPGA_ID,
    parameter opb_word_t build_date = DEF_BUILD_DATE
) (
    input  logic      opb_clk,
    input  logic      rst_n,
    input  logic      sel,
    input  opb_req_t  opb_req,
    output opb_word_t rdata
);

    localparam logic [7:0] ofs_version = 8'd0;
    localparam logic [7:0] ofs_id      = 8'd1;
    localparam logic [7:0] ofs_date    = 8'd2;
    localparam logic [7:0] ofs_scratch = 8'd3;

    opb_word_t scratch_q;                           // Software scratch word

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch_q <= '0;
        end else if (sel && opb_req.we && opb_req.addr.fields.offset == ofs_scratch) begin
            scratch_q <= opb_req.wdata;
        end
    end

    // Read word follows the offset continuously
    always_comb begin
        case (opb_req.addr.fields.offset)
            ofs_version: rdata = fw_version;        // Read only
            ofs_id:      rdata = fpga_id;           // Read only
            ofs_date:    rdata = build_date;        // Read only
            ofs_scratch: rdata = scratch_q;
            default:     rdata = UNMAPPED_READ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/tick_gen.sv
/*
 * Fast tick pulse and slow square wave derived from opb_clk, with a bus
 * enable bit and a count of slow toggles for software.
 */
`timescale 1ns/10ps
`default_nettype none

module tick_gen import app_pkg::*; #(
    parameter int unsigned clks_per_tick    = 50000,
    parameter int unsigned ticks_per_toggle = 1000
) (
    input  logic      opb_clk,
    input  logic      rst_n,
    input  logic      sel,
    input  opb_req_t  opb_req,
    output logic      tick,
    output logic      slow_sq,
    output opb_word_t rdata
);

    localparam int cyc_w = $clog2(clks_per_tick + 1);
    localparam int tck_w = $clog2(ticks_per_toggle + 1);
    localparam logic [cyc_w-1:0] cyc_last = cyc_w'(clks_per_tick - 1);
    localparam logic [tck_w-1:0] tck_last = tck_w'(ticks_per_toggle - 1);
    localparam logic [7:0] ofs_ctrl   = 8'd0;
    localparam logic [7:0] ofs_toggle = 8'd1;

    logic             en_q;                         // Control bit 0
    logic [cyc_w-1:0] cyc_cnt;                      // Clocks inside one tick
    logic [tck_w-1:0] tck_cnt;                      // Ticks inside one half period
    logic [15:0]      toggle_cnt;                   // Slow toggles since reset

    assign tick = en_q && (cyc_cnt == cyc_last);    // One cycle wide

    // ======================================================================
    // Counters
    // ======================================================================

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q       <= 1'b1;                     // Running out of reset
            cyc_cnt    <= '0;
            tck_cnt    <= '0;
            slow_sq    <= 1'b0;
            toggle_cnt <= '0;
        end else begin
            if (sel && opb_req.we && opb_req.addr.fields.offset == ofs_ctrl) begin
                en_q <= opb_req.wdata[0];
            end
            if (!en_q) begin
                cyc_cnt <= '0;                      // Restart from a full period
            end else if (tick) begin
                cyc_cnt <= '0;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
            if (tick) begin
                if (tck_cnt == tck_last) begin
                    tck_cnt    <= '0;
                    slow_sq    <= ~slow_sq;
                    toggle_cnt <= toggle_cnt + 1'b1;    // Wraps at 16 bits
                end else begin
                    tck_cnt <= tck_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (opb_req.addr.fields.offset)
            ofs_ctrl:   rdata = {30'd0, slow_sq, en_q};
            ofs_toggle: rdata = {16'd0, toggle_cnt};
            default:    rdata = UNMAPPED_READ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/gpio_regs.sv
/*
 * GPIO block with synchronized inputs, an output latch and the LED register.
 * Also holds the bus wake-up flag that moves the heartbeat LED to software.
 */
`timescale 1ns/10ps
`default_nettype none

module gpio_regs import app_pkg::*; (
    input  logic                  opb_clk,
    input  logic                  rst_n,
    input  logic                  sel,
    input  logic                  slow_sq,
    input  opb_req_t              opb_req,
    input  logic [GPIO_IN_W-1:0]  gpio_in,
    output logic [GPIO_OUT_W-1:0] gpio_out,
    output logic [LED_W-1:0]      stat_led_n,
    output logic                  heartbeat_led_n,
    output opb_word_t             rdata
);

    localparam logic [7:0] ofs_in  = 8'd0;
    localparam logic [7:0] ofs_out = 8'd1;
    localparam logic [7:0] ofs_led = 8'd2;

    logic [GPIO_IN_W-1:0] in_meta;                  // First synchronizer stage
    logic [GPIO_IN_W-1:0] in_sync;                  // Second stage, read by software
    logic [LED_W:0]       led_q;                    // Status LEDs plus heartbeat on top
    logic                 wakeup_q;                 // Set by the first bus access
    logic                 wr_en;

    assign wr_en = sel && opb_req.we;

    // ======================================================================
    // Input synchronizer
    // ======================================================================

    always_ff @(posedge opb_clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    // ======================================================================
    // Output latch, LED register and wake-up flag
    // ======================================================================

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out <= '0;
            led_q    <= '0;                         // All LEDs dark
            wakeup_q <= 1'b0;
        end else begin
            if (wr_en && opb_req.addr.fields.offset == ofs_out) begin
                gpio_out <= opb_req.wdata[GPIO_OUT_W-1:0];
            end
            if (wr_en && opb_req.addr.fields.offset == ofs_led) begin
                led_q <= opb_req.wdata[LED_W:0];
            end
            if (opb_req.re || opb_req.we) begin
                wakeup_q <= 1'b1;                   // Any block counts
            end
        end
    end

    // Pins are active low
    assign stat_led_n = ~led_q[LED_W-1:0];

    // Slow blink until software has touched the bus
    assign heartbeat_led_n = wakeup_q ? ~led_q[LED_W] : slow_sq;

    always_comb begin
        case (opb_req.addr.fields.offset)
            ofs_in:  rdata = opb_word_t'(in_sync);
            ofs_out: rdata = opb_word_t'(gpio_out);
            ofs_led: rdata = opb_word_t'(led_q);    // Bit 3 is heartbeat
            default: rdata = UNMAPPED_READ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/app_top.sv
/*
 * Register core top level. Carries the build parameters and ties the decoder
 * to the identity, tick and GPIO blocks on one shared bus.
 */
`timescale 1ns/10ps
`default_nettype none

module app_top import app_pkg::*; #(
    parameter opb_word_t   fw_version       = DEF_FW_VERSION,
    parameter opb_word_t   fpga_id          = DEF_FPGA_ID,
    parameter opb_word_t   build_date       = DEF_BUILD_DATE,
    parameter int unsigned clks_per_tick    = 50000,    // 2 kHz at 100 MHz
    parameter int unsigned ticks_per_toggle = 1000      // 1 Hz square
) (
    input  logic                  opb_clk,
    input  logic                  rst_n,
    input  opb_req_t              opb_req,
    input  logic [GPIO_IN_W-1:0]  gpio_in,
    output opb_word_t             opb_rdata,
    output logic                  tick_out,         // Replaces the 2 kHz clock out
    output logic [GPIO_OUT_W-1:0] gpio_out,
    output logic [LED_W-1:0]      stat_led_n,
    output logic                  heartbeat_led_n
);

    blk_sel_t  sel;                                 // One-hot block selects
    opb_word_t idreg_rdata;
    opb_word_t tick_rdata;
    opb_word_t gpio_rdata;
    logic      slow_sq;                             // Slow blink for the heartbeat

    // ======================================================================
    // Decoder and peripherals
    // ======================================================================

    opb_addr_decode u_decode (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .opb_req     (opb_req),
        .idreg_rdata (idreg_rdata),
        .tick_rdata  (tick_rdata),
        .gpio_rdata  (gpio_rdata),
        .sel         (sel),
        .opb_rdata   (opb_rdata)
    );

    id_scratch_regs #(
        .fw_version (fw_version),
        .fpga_id    (fpga_id),
        .build_date (build_date)
    ) u_idreg (
        .opb_clk (opb_clk),
        .rst_n   (rst_n),
        .sel     (sel.idreg),
        .opb_req (opb_req),
        .rdata   (idreg_rdata)
    );

    tick_gen #(
        .clks_per_tick    (clks_per_tick),
        .ticks_per_toggle (ticks_per_toggle)
    ) u_tick (
        .opb_clk (opb_clk),
        .rst_n   (rst_n),
        .sel     (sel.tick),
        .opb_req (opb_req),
        .tick    (tick_out),                        // Straight to the pin
        .slow_sq (slow_sq),
        .rdata   (tick_rdata)
    );

    gpio_regs u_gpio (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .sel             (sel.gpio),
        .slow_sq         (slow_sq),
        .opb_req         (opb_req),
        .gpio_in         (gpio_in),
        .gpio_out        (gpio_out),
        .stat_led_n      (stat_led_n),
        .heartbeat_led_n (heartbeat_led_n),
        .rdata           (gpio_rdata)
    );

endmodule

`default_nettype wire

//--- dv/tb_opb_tasks.svh
/*
 * Bus access and bounded wait tasks for the register core testbench.
 * Included inside the testbench module, so the tasks drive its signals directly.
 */
`ifndef TB_OPB_TASKS_SVH
`define TB_OPB_TASKS_SVH

// Write lands on the rising edge between the two falling edges
task automatic opb_write(input logic [7:0] blk, input logic [7:0] ofs,
                         input logic [31:0] data);
    @(negedge opb_clk);
    opb_req.addr.raw = {16'h0000, blk, ofs};
    opb_req.wdata    = data;
    opb_req.we       = 1'b1;                        // One cycle strobe
    @(negedge opb_clk);
    opb_req.we = 1'b0;
endtask

task automatic opb_read(input logic [7:0] blk, input logic [7:0] ofs,
                        output logic [31:0] data);
    @(negedge opb_clk);
    opb_req.addr.raw = {16'h0000, blk, ofs};
    opb_req.re       = 1'b1;
    @(negedge opb_clk);
    opb_req.re = 1'b0;
    data       = opb_rdata;                         // Registered one cycle back
endtask

// Cycles until the next tick_out pulse
task automatic wait_tick(input int limit, output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
        @(negedge opb_clk);
        cycles++;
        seen = tick_out;
    end
    if (!seen) begin
        timeouts++;
        $display("Timeout: no tick_out pulse within %0d cycles", limit);
    end
endtask

// Cycles until heartbeat_led_n changes level
task automatic wait_hb_edge(input int limit, output int cycles);
    logic start;
    start  = heartbeat_led_n;
    cycles = 0;
    while (heartbeat_led_n == start && cycles < limit) begin
        @(negedge opb_clk);
        cycles++;
    end
    if (heartbeat_led_n == start) begin
        timeouts++;
        $display("Timeout: heartbeat LED did not change within %0d cycles", limit);
    end
endtask

// Polls tick control until the slow square bit flips
task automatic wait_sq_toggle(input int limit, output int reads);
    logic [31:0] rd;
    logic        start;
    opb_read(BLK_TICK, 8'd0, rd);
    start = rd[1];
    reads = 0;
    while (rd[1] == start && reads < limit) begin
        opb_read(BLK_TICK, 8'd0, rd);
        reads++;
    end
    if (rd[1] == start) begin
        timeouts++;
        $display("Timeout: slow square did not toggle within %0d reads", limit);
    end
endtask

`endif

//--- dv/app_top_tb.sv
/*
 * Testbench for the register core. Drives the bus on the falling clock edge and
 * checks identity, scratch, GPIO, heartbeat and tick behavior with assertions.
 */
`timescale 1ns/10ps
`default_nettype none

module app_top_tb import app_pkg::*; ();

    localparam opb_word_t exp_version = 32'h0003_0102;  // Build words given to the DUT
    localparam opb_word_t exp_id      = 32'h0000_0a5c;
    localparam opb_word_t exp_date    = 32'hb1d0_0042;

    logic                  opb_clk;
    logic                  rst_n;
    opb_req_t              opb_req;
    logic [GPIO_IN_W-1:0]  gpio_in;
    opb_word_t             opb_rdata;
    logic                  tick_out;
    logic [GPIO_OUT_W-1:0] gpio_out;
    logic [LED_W-1:0]      stat_led_n;
    logic                  heartbeat_led_n;
    int                    errors;                  // Failed value checks
    int                    timeouts;                // Waits that ran out
    logic [15:0]           lfsr;                    // Stimulus LFSR state

    `include "tb_opb_tasks.svh"

    app_top #(
        .fw_version       (exp_version),
        .fpga_id          (exp_id),
        .build_date       (exp_date),
        .clks_per_tick    (10),
        .ticks_per_toggle (4)
    ) app_top_i (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .opb_req         (opb_req),
        .gpio_in         (gpio_in),
        .opb_rdata       (opb_rdata),
        .tick_out        (tick_out),
        .gpio_out        (gpio_out),
        .stat_led_n      (stat_led_n),
        .heartbeat_led_n (heartbeat_led_n)
    );

    initial begin
        opb_clk = 1'b0;
        forever #20 opb_clk = ~opb_clk;             // 40 ns period
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_word(input int nbits, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);                 // One step per bit
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // Tick must be a single cycle pulse
    single_tick: assert property (@(posedge opb_clk) disable iff (!rst_n)
                                  tick_out |=> !tick_out)
        else begin
            errors++;
            $display("tick_out stayed high for more than one cycle");
        end

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        logic [15:0] cnt0;
        logic        sq_prev;
        int          n;
        int          toggles;
        errors   = 0;
        timeouts = 0;
        lfsr     = 16'd98;                          // Seed
        opb_req  = '0;
        gpio_in  = '0;
        rst_n    = 1'b0;
        repeat (3) @(posedge opb_clk);              // Three edges held in reset
        @(negedge opb_clk);
        rst_n = 1'b1;

        // Reset state and free-running blink before any bus access
        check_word("gpio_out", {16'd0, gpio_out}, 32'h0);
        check_word("stat_led_n", {29'd0, stat_led_n}, 32'h7);
        wait_tick(20, n);
        wait_tick(20, n);
        check_word("tick_out period", n, 10);
        wait_hb_edge(100, n);
        wait_hb_edge(100, n);
        check_word("heartbeat_led_n half period", n, 40);   // 4 ticks of 10

        // Identity words and unmapped space
        opb_read(BLK_IDREG, 8'd0, rd);
        check_word("opb_rdata version", rd, exp_version);
        opb_read(BLK_IDREG, 8'd1, rd);
        check_word("opb_rdata fpga id", rd, exp_id);
        opb_read(BLK_IDREG, 8'd2, rd);
        check_word("opb_rdata build date", rd, exp_date);
        opb_read(8'h07, 8'd0, rd);
        check_word("opb_rdata unmapped block", rd, 32'h0);
        opb_read(BLK_IDREG, 8'h10, rd);
        check_word("opb_rdata unmapped offset", rd, 32'h0);
        check_word("heartbeat_led_n", {31'd0, heartbeat_led_n}, 32'h1);  // LED bit 3 clear

        repeat (4) begin
            rand_word(32, val);
            opb_write(BLK_IDREG, 8'd3, val);
            opb_read(BLK_IDREG, 8'd3, rd);
            check_word("opb_rdata scratch", rd, val);
        end

        // GPIO inputs through the two stage synchronizer
        rand_word(16, val);
        @(negedge opb_clk);
        gpio_in = val[15:0];
        repeat (3) @(negedge opb_clk);
        opb_read(BLK_GPIO, 8'd0, rd);
        check_word("opb_rdata gpio_in", rd, {16'd0, val[15:0]});
        rand_word(16, val);
        opb_write(BLK_GPIO, 8'd1, val);
        check_word("gpio_out", {16'd0, gpio_out}, val);
        opb_read(BLK_GPIO, 8'd1, rd);
        check_word("opb_rdata gpio_out", rd, val);

        // LED pins and software heartbeat across a slow toggle
        for (int i = 0; i < 2; i++) begin
            rand_word(3, val);
            val[3] = i[0];                          // Both heartbeat levels
            opb_write(BLK_GPIO, 8'd2, val);
            check_word("stat_led_n", {29'd0, stat_led_n}, {29'd0, ~val[2:0]});
            check_word("heartbeat_led_n", {31'd0, heartbeat_led_n}, {31'd0, ~val[3]});
            opb_read(BLK_GPIO, 8'd2, rd);
            check_word("opb_rdata led", rd, {28'd0, val[3:0]});
            wait_sq_toggle(40, n);
            check_word("heartbeat_led_n", {31'd0, heartbeat_led_n}, {31'd0, ~val[3]});
        end

        // Tick stop, restart and toggle count
        opb_write(BLK_TICK, 8'd0, 32'h0);
        opb_read(BLK_TICK, 8'd1, rd);
        cnt0 = rd[15:0];
        n    = 0;
        repeat (50) begin
            @(negedge opb_clk);
            if (tick_out) n++;
        end
        check_word("tick_out pulses while stopped", n, 0);
        opb_read(BLK_TICK, 8'd1, rd);
        check_word("opb_rdata toggle count", rd, {16'd0, cnt0});
        opb_read(BLK_TICK, 8'd0, rd);
        check_word("opb_rdata tick enable", {31'd0, rd[0]}, 32'h0);
        sq_prev = rd[1];                            // Frozen while stopped
        opb_write(BLK_TICK, 8'd0, 32'h1);
        wait_tick(10, n);
        toggles = 0;
        repeat (100) begin
            opb_read(BLK_TICK, 8'd0, rd);
            if (rd[1] != sq_prev) toggles++;
            sq_prev = rd[1];
        end
        opb_write(BLK_TICK, 8'd0, 32'h0);
        opb_read(BLK_TICK, 8'd0, rd);
        if (rd[1] != sq_prev) toggles++;            // Edge just before the stop
        opb_read(BLK_TICK, 8'd1, rd);
        check_word("opb_rdata toggle count", rd, {16'd0, cnt0 + 16'(toggles)});

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+dv
source/app_pkg.sv
source/opb_addr_decode.sv
source/id_scratch_regs.sv
source/tick_gen.sv
source/gpio_regs.sv
source/app_top.sv
dv/app_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the register core testbench with Verilator and runs it.
# The result comes from the pass line in sim.log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module app_top_tb -o app_sim \
    && ./obj_dir/app_sim | tee sim.log \
    && grep -q "Test passed" sim.log \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }
